//--- Makefile
TOP = cpuExecTb

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- include/cpuExec_cfg.svh
// ################################################
// Build-time options for the execute stage
// CPU_MODE 0 builds Z80, 3 builds GameBoy, others act as Z80
// REG_COUNT must stay 8 to match the 3-bit register index
// ################################################
`ifndef CPU_EXEC_CFG_SVH
`define CPU_EXEC_CFG_SVH

// Processor variant
`define CPU_MODE 0

// Byte registers B C D E H L M A
`define REG_COUNT 8

`endif

//--- source/cpuAlu.sv
// ################################################
// Purely combinational, flags in and out in Z80 layout
// No 16-bit arithmetic and no RLD/RRD
// BIT with operand field 6 clears X and Y
// ################################################
`timescale 1ns/1ps
`include "cpuExec_cfg.svh"

module cpuAlu (
  input  cpuAluPkg::aluOpE   aluOp,
  input  cpuAluPkg::iSetE    iSet,
  input  cpuAluPkg::irField  irBits,
  input  cpuAluPkg::dataByte busA,
  input  cpuAluPkg::dataByte busB,
  input  cpuAluPkg::flagByte flagIn,
  output cpuAluPkg::dataByte result,
  output cpuAluPkg::flagByte flagOut
);
  import cpuAluPkg::*;
  import cpuRegPkg::*;

  localparam bit GB_MODE = (`CPU_MODE == 3);

  logic       subOp;       // SUB, SBC, CP
  logic       useCarry;    // ADC, SBC
  logic       carryIn;
  dataByte    opB;         // Second operand, inverted for subtract
  logic [3:0] sumLo;
  logic [2:0] sumMid;
  logic       sumHi;
  logic       halfCarry;   // Out of bit 3
  logic       carryInto7;  // Out of bit 6
  logic       carryOut;    // Out of bit 7
  logic       overflow;
  dataByte    sum;

  dataByte    bitMask;
  dataByte    rotVal;
  logic       rotCarry;

  logic       daaLowAdj;
  logic       daaHighAdj;
  logic       daaHalf;
  dataByte    daaCorr;
  dataByte    daaVal;

  dataByte    aluVal;

  assign subOp    = aluOp[1];
  assign useCarry = ~aluOp[2] & aluOp[0];
  assign carryIn  = subOp ^ (useCarry & flagIn[FLAG_C]);  // Borrow enters inverted
  assign opB      = subOp ? ~busB : busB;

  // Split adder exposes carries at bits 3, 6 and 7
  assign {halfCarry, sumLo}   = {1'b0, busA[3:0]} + {1'b0, opB[3:0]} + {4'b0, carryIn};
  assign {carryInto7, sumMid} = {1'b0, busA[6:4]} + {1'b0, opB[6:4]} + {3'b0, halfCarry};
  assign {carryOut, sumHi}    = {1'b0, busA[7]} + {1'b0, opB[7]} + {1'b0, carryInto7};
  assign overflow = carryOut ^ carryInto7;
  assign sum      = {sumHi, sumMid, sumLo};

  assign bitMask = 8'd1 << irBits[5:3];

  // GameBoy after subtract trusts only the flags
  assign daaLowAdj  = (GB_MODE && flagIn[FLAG_N]) ? flagIn[FLAG_H]
                                                  : (flagIn[FLAG_H] || busA[3:0] > 4'd9);
  assign daaHighAdj = (GB_MODE && flagIn[FLAG_N]) ? flagIn[FLAG_C]
                                                  : (flagIn[FLAG_C] || busA > 8'h99);
  assign daaCorr    = {daaHighAdj ? 4'h6 : 4'h0, daaLowAdj ? 4'h6 : 4'h0};
  assign daaVal     = flagIn[FLAG_N] ? busA - daaCorr : busA + daaCorr;
  assign daaHalf    = GB_MODE ? 1'b0
                    : flagIn[FLAG_N] ? (flagIn[FLAG_H] && busA[3:0] < 4'd6)
                                     : (busA[3:0] > 4'd9);

  // Rotate and shift kinds from bits 5:3
  always_comb
  begin
    rotCarry = busA[7];
    case (irBits[5:3])
      3'd0: rotVal = {busA[6:0], busA[7]};          // RLC
      3'd1:                                         // RRC
      begin
        rotVal   = {busA[0], busA[7:1]};
        rotCarry = busA[0];
      end
      3'd2: rotVal = {busA[6:0], flagIn[FLAG_C]};   // RL through carry
      3'd3:                                         // RR through carry
      begin
        rotVal   = {flagIn[FLAG_C], busA[7:1]};
        rotCarry = busA[0];
      end
      3'd4: rotVal = {busA[6:0], 1'b0};             // SLA
      3'd5:                                         // SRA keeps sign
      begin
        rotVal   = {busA[7], busA[7:1]};
        rotCarry = busA[0];
      end
      3'd6:
      begin
        if (GB_MODE)
        begin
          rotVal   = {busA[3:0], busA[7:4]};        // SWAP nibbles
          rotCarry = 1'b0;
        end
        else
        begin
          rotVal = {busA[6:0], 1'b1};               // SLL, undocumented
        end
      end
      default:                                      // SRL
      begin
        rotVal   = {1'b0, busA[7:1]};
        rotCarry = busA[0];
      end
    endcase
  end

  always_comb
  begin
    aluVal  = busA;
    flagOut = flagIn;  // SET, RES and unused codes keep F
    case (aluOp)
      ADD, ADC, SUB, SBC, CP:
      begin
        aluVal          = sum;
        flagOut[FLAG_N] = subOp;
        flagOut[FLAG_C] = carryOut ^ subOp;   // Borrow is inverted carry
        flagOut[FLAG_H] = halfCarry ^ subOp;
        flagOut[FLAG_P] = overflow;
        flagOut[FLAG_S] = aluVal[7];
        flagOut[FLAG_Z] = (aluVal == 8'h00);
        flagOut[FLAG_X] = (aluOp == CP) ? busB[3] : aluVal[3];
        flagOut[FLAG_Y] = (aluOp == CP) ? busB[5] : aluVal[5];
      end
      AND, XOR, OR:
      begin
        if (aluOp == AND)
          aluVal = busA & busB;
        else if (aluOp == XOR)
          aluVal = busA ^ busB;
        else
          aluVal = busA | busB;
        flagOut[FLAG_N] = 1'b0;
        flagOut[FLAG_C] = 1'b0;
        flagOut[FLAG_H] = (aluOp == AND);
        flagOut[FLAG_P] = ~(^aluVal);         // Even parity
        flagOut[FLAG_S] = aluVal[7];
        flagOut[FLAG_Z] = (aluVal == 8'h00);
        flagOut[FLAG_X] = aluVal[3];
        flagOut[FLAG_Y] = aluVal[5];
      end
      ROT:
      begin
        aluVal          = rotVal;
        flagOut[FLAG_C] = rotCarry;
        flagOut[FLAG_N] = 1'b0;
        flagOut[FLAG_H] = 1'b0;
        flagOut[FLAG_X] = aluVal[3];
        flagOut[FLAG_Y] = aluVal[5];
        flagOut[FLAG_S] = aluVal[7];
        flagOut[FLAG_Z] = (aluVal == 8'h00);
        flagOut[FLAG_P] = ~(^aluVal);
        if (iSet == PLAIN)                    // RLCA, RRCA, RLA, RRA
        begin
          flagOut[FLAG_S] = GB_MODE ? 1'b0 : flagIn[FLAG_S];
          flagOut[FLAG_Z] = GB_MODE ? 1'b0 : flagIn[FLAG_Z];
          flagOut[FLAG_P] = GB_MODE ? 1'b0 : flagIn[FLAG_P];
        end
      end
      BIT:
      begin
        aluVal          = busB & bitMask;     // Not written back
        flagOut[FLAG_S] = aluVal[7];
        flagOut[FLAG_Z] = (aluVal == 8'h00);
        flagOut[FLAG_P] = (aluVal == 8'h00);  // Mirrors Z
        flagOut[FLAG_H] = 1'b1;
        flagOut[FLAG_N] = 1'b0;
        flagOut[FLAG_X] = (irBits[2:0] != REG_M) && busB[3];
        flagOut[FLAG_Y] = (irBits[2:0] != REG_M) && busB[5];
      end
      SET: aluVal = busB | bitMask;
      RES: aluVal = busB & ~bitMask;
      DAA:
      begin
        aluVal          = daaVal;
        flagOut[FLAG_C] = daaHighAdj;         // Carry sticks once set
        flagOut[FLAG_H] = daaHalf;
        flagOut[FLAG_S] = aluVal[7];
        flagOut[FLAG_Z] = (aluVal == 8'h00);
        flagOut[FLAG_P] = ~(^aluVal);
        flagOut[FLAG_X] = aluVal[3];
        flagOut[FLAG_Y] = aluVal[5];
      end
      default: ;
    endcase
  end

  assign result = aluVal;

endmodule

//--- source/cpuAluPkg.sv
// ################################################
// ALU level types shared by decoder, ALU and top
// Decoder casts opcode bits 5:3 straight onto the enum codes
// ################################################
package cpuAluPkg;

  typedef logic [7:0] dataByte;   // Register or bus value
  typedef logic [7:0] flagByte;   // Flag register image
  typedef logic [5:0] irField;    // Opcode bits 5:0 for the ALU

  // Low eight ALU operations follow the order of the 80-BF group
  typedef enum logic [3:0] {
    ADD = 4'd0,
    ADC = 4'd1,
    SUB = 4'd2,
    SBC = 4'd3,
    AND = 4'd4,
    XOR = 4'd5,
    OR  = 4'd6,
    CP  = 4'd7,
    ROT = 4'd8,   // Rotates and shifts
    BIT = 4'd9,
    SET = 4'd10,
    RES = 4'd11,
    DAA = 4'd12
  } aluOpE;

  // Instruction set class
  typedef enum logic [1:0] {
    PLAIN = 2'd0,  // Unprefixed
    CB    = 2'd1   // CB prefix
  } iSetE;

endpackage

//--- source/cpuExecTop.sv
// ################################################
// Execute stage, one opcode per issue strobe
// Results and flags visible one cycle after issue
// ################################################
`timescale 1ns/1ps

module cpuExecTop (
  input  logic               clk,
  input  logic               rstN,
  input  logic               issue,
  input  logic               cbPrefix,
  input  cpuAluPkg::dataByte opcode,
  input  logic               loadEn,
  input  cpuRegPkg::regIdx   loadSel,
  input  cpuAluPkg::dataByte loadData,
  input  logic               flagLoadEn,
  input  cpuAluPkg::flagByte flagLoadData,
  input  cpuRegPkg::regIdx   regSel,
  output cpuAluPkg::dataByte regData,
  output cpuAluPkg::flagByte flagOut
);
  import cpuAluPkg::*;
  import cpuRegPkg::*;

  aluOpE   aluOp;
  iSetE    iSet;
  irField  irBits;
  regIdx   aSel;
  regIdx   bSel;
  regIdx   dstSel;
  logic    regWr;
  logic    opValid;
  dataByte busA;
  dataByte busB;
  dataByte result;
  flagByte aluFlagIn;    // Z80 layout
  flagByte aluFlagOut;   // Z80 layout

  cpuOpDecode u_decode (
    .cbPrefix(cbPrefix), .opcode(opcode), .aluOp(aluOp), .iSet(iSet), .irBits(irBits),
    .aSel(aSel), .bSel(bSel), .dstSel(dstSel), .regWr(regWr), .opValid(opValid)
  );

  cpuRegFile u_regFile (
    .clk(clk), .rstN(rstN), .issue(issue), .opValid(opValid), .regWr(regWr),
    .dstSel(dstSel), .result(result), .aluFlagOut(aluFlagOut), .aSel(aSel), .bSel(bSel),
    .busA(busA), .busB(busB), .aluFlagIn(aluFlagIn), .loadEn(loadEn), .loadSel(loadSel),
    .loadData(loadData), .flagLoadEn(flagLoadEn), .flagLoadData(flagLoadData),
    .regSel(regSel), .regData(regData), .flagOut(flagOut)
  );

  cpuAlu u_alu (
    .aluOp(aluOp), .iSet(iSet), .irBits(irBits), .busA(busA), .busB(busB),
    .flagIn(aluFlagIn), .result(result), .flagOut(aluFlagOut)
  );

endmodule

//--- source/cpuOpDecode.sv
// ################################################
// Combinational decode of one opcode byte
// cbPrefix must be held with the CB opcode itself
// Unsupported opcodes drop opValid low
// ################################################
`timescale 1ns/1ps

module cpuOpDecode (
  input  logic               cbPrefix,
  input  cpuAluPkg::dataByte opcode,
  output cpuAluPkg::aluOpE   aluOp,
  output cpuAluPkg::iSetE    iSet,
  output cpuAluPkg::irField  irBits,
  output cpuRegPkg::regIdx   aSel,
  output cpuRegPkg::regIdx   bSel,
  output cpuRegPkg::regIdx   dstSel,
  output logic               regWr,
  output logic               opValid
);
  import cpuAluPkg::*;
  import cpuRegPkg::*;

  always_comb
  begin
    aluOp   = ADD;
    iSet    = PLAIN;
    irBits  = opcode[5:0];   // Bit number or rotate kind plus operand
    aSel    = REG_A;
    bSel    = opcode[2:0];
    dstSel  = REG_A;
    regWr   = 1'b0;
    opValid = 1'b0;

    if (cbPrefix)
    begin
      // Operand is both source and destination
      iSet    = CB;
      aSel    = opcode[2:0];
      dstSel  = opcode[2:0];
      regWr   = 1'b1;
      opValid = 1'b1;
      case (opcode[7:6])
        2'b00: aluOp = ROT;
        2'b01:
        begin
          aluOp = BIT;
          regWr = 1'b0;      // Test only
        end
        2'b10: aluOp = RES;
        default: aluOp = SET;
      endcase
    end
    else if (opcode[7:6] == 2'b10)
    begin
      // 80-BF, A op r
      aluOp   = aluOpE'({1'b0, opcode[5:3]});
      regWr   = (opcode[5:3] != 3'b111);  // CP only compares
      opValid = 1'b1;
    end
    else
    begin
      case (opcode)
        8'h27:
        begin
          aluOp   = DAA;
          regWr   = 1'b1;
          opValid = 1'b1;
        end
        8'h07, 8'h0F, 8'h17, 8'h1F:   // RLCA RRCA RLA RRA
        begin
          aluOp   = ROT;
          regWr   = 1'b1;
          opValid = 1'b1;
        end
        default: ;                    // Not handled here
      endcase
    end
  end

endmodule

//--- source/cpuRegFile.sv
// ################################################
// Register bank and F, written on the issue edge
// F is held in native layout, ALU side is always Z80 layout
// A load in the same cycle as issue is lost
// ################################################
`timescale 1ns/1ps
`include "cpuExec_cfg.svh"

module cpuRegFile (
  input  logic               clk,
  input  logic               rstN,
  input  logic               issue,
  input  logic               opValid,
  input  logic               regWr,
  input  cpuRegPkg::regIdx   dstSel,
  input  cpuAluPkg::dataByte result,
  input  cpuAluPkg::flagByte aluFlagOut,
  input  cpuRegPkg::regIdx   aSel,
  input  cpuRegPkg::regIdx   bSel,
  output cpuAluPkg::dataByte busA,
  output cpuAluPkg::dataByte busB,
  output cpuAluPkg::flagByte aluFlagIn,
  input  logic               loadEn,
  input  cpuRegPkg::regIdx   loadSel,
  input  cpuAluPkg::dataByte loadData,
  input  logic               flagLoadEn,
  input  cpuAluPkg::flagByte flagLoadData,
  input  cpuRegPkg::regIdx   regSel,
  output cpuAluPkg::dataByte regData,
  output cpuAluPkg::flagByte flagOut
);
  import cpuAluPkg::*;
  import cpuRegPkg::*;

  localparam bit GB_MODE = (`CPU_MODE == 3);

  dataByte regs [0:`REG_COUNT-1];
  flagByte flagReg;   // Native layout

  // Native to Z80 layout
  function automatic flagByte toZ80(input flagByte native);
    flagByte z80;
    z80 = native;
    if (GB_MODE)
    begin
      z80         = 8'h00;   // S, P, X, Y do not exist on GameBoy
      z80[FLAG_Z] = native[GB_Z];
      z80[FLAG_N] = native[GB_N];
      z80[FLAG_H] = native[GB_H];
      z80[FLAG_C] = native[GB_C];
    end
    return z80;
  endfunction

  // Z80 to native layout
  function automatic flagByte fromZ80(input flagByte z80);
    flagByte native;
    native = z80;
    if (GB_MODE)
    begin
      native       = 8'h00;
      native[GB_Z] = z80[FLAG_Z];
      native[GB_N] = z80[FLAG_N];
      native[GB_H] = z80[FLAG_H];
      native[GB_C] = z80[FLAG_C];
    end
    return native;
  endfunction

  assign busA      = regs[aSel];
  assign busB      = regs[bSel];
  assign aluFlagIn = toZ80(flagReg);
  assign regData   = regs[regSel];
  assign flagOut   = flagReg;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
      flagReg <= '0;
    end
    else if (issue)
    begin
      if (opValid)                         // Invalid opcode is a no-op
      begin
        flagReg <= fromZ80(aluFlagOut);
        if (regWr)
          regs[dstSel] <= result;
      end
    end
    else
    begin
      if (loadEn)
        regs[loadSel] <= loadData;
      if (flagLoadEn)
        flagReg <= GB_MODE ? {flagLoadData[7:4], 4'h0} : flagLoadData;  // GB low nibble is 0
    end
  end

endmodule

//--- source/cpuRegPkg.sv
// ################################################
// Register indices and flag bit positions
// Indices follow the Z80 operand field, 6 is the M scratch byte
// ################################################
package cpuRegPkg;

  typedef logic [2:0] regIdx;

  // Operand field encoding
  localparam regIdx REG_B = 3'd0;
  localparam regIdx REG_C = 3'd1;
  localparam regIdx REG_D = 3'd2;
  localparam regIdx REG_E = 3'd3;
  localparam regIdx REG_H = 3'd4;
  localparam regIdx REG_L = 3'd5;
  localparam regIdx REG_M = 3'd6;  // Stands in for (HL)
  localparam regIdx REG_A = 3'd7;

  // Z80 flag layout, the ALU always works in this one
  localparam int FLAG_C = 0;
  localparam int FLAG_N = 1;
  localparam int FLAG_P = 2;  // Parity or overflow
  localparam int FLAG_X = 3;  // Undocumented copy of bit 3
  localparam int FLAG_H = 4;
  localparam int FLAG_Y = 5;  // Undocumented copy of bit 5
  localparam int FLAG_Z = 6;
  localparam int FLAG_S = 7;

  // GameBoy layout, low nibble reads as zero
  localparam int GB_Z = 7;
  localparam int GB_N = 6;
  localparam int GB_H = 5;
  localparam int GB_C = 4;

endpackage

//--- verif/cpuExecTb.sv
// ################################################
// Table-driven testbench for the execute stage, Z80 build only
// Expected bytes and flags are hand-computed Z80 values
// Random picks of B to E use a fixed seed
// ################################################
`timescale 1ns/1ps

module cpuExecTb;
  import cpuAluPkg::*;
  import cpuRegPkg::*;

  localparam int MAX_TESTS = 40;

  logic    clk;
  logic    rstN;
  logic    issue;
  logic    cbPrefix;
  dataByte opcode;
  logic    loadEn;
  regIdx   loadSel;
  dataByte loadData;
  logic    flagLoadEn;
  flagByte flagLoadData;
  regIdx   regSel;
  dataByte regData;
  flagByte flagOut;

  // Test table, one column per array
  string   tName    [MAX_TESTS];
  dataByte aVal     [MAX_TESTS];   // Preload for A
  dataByte opVal    [MAX_TESTS];   // Preload for the operand register
  regIdx   opIdx    [MAX_TESTS];
  flagByte fVal     [MAX_TESTS];
  dataByte opCode   [MAX_TESTS];
  bit      cbFlag   [MAX_TESTS];
  bit      pickReg  [MAX_TESTS];   // Operand chosen at random from B to E
  bit      readOp   [MAX_TESTS];   // Read back operand, else A
  dataByte expByte  [MAX_TESTS];
  flagByte expFlags [MAX_TESTS];
  int      nTests = 0;

  integer  seed = 32'hd7e;
  int      errors = 0;
  int      passCount = 0;
  int      failCount = 0;
  int      cycles = 0;
  int      cycleLimit = 50;

  cpuExecTop u_dut (
    .clk(clk), .rstN(rstN), .issue(issue), .cbPrefix(cbPrefix), .opcode(opcode),
    .loadEn(loadEn), .loadSel(loadSel), .loadData(loadData), .flagLoadEn(flagLoadEn),
    .flagLoadData(flagLoadData), .regSel(regSel), .regData(regData), .flagOut(flagOut)
  );

  always #50 clk = ~clk;   // 100 ns period

  // Watchdog
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit)
    begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic addTest(input string name, input dataByte a, input dataByte opv,
                         input regIdx idx, input flagByte f, input dataByte op, input bit cb,
                         input bit pick, input bit rdOp, input dataByte eByte,
                         input flagByte eFlags);
    tName[nTests]    = name;
    aVal[nTests]     = a;
    opVal[nTests]    = opv;
    opIdx[nTests]    = idx;
    fVal[nTests]     = f;
    opCode[nTests]   = op;
    cbFlag[nTests]   = cb;
    pickReg[nTests]  = pick;
    readOp[nTests]   = rdOp;
    expByte[nTests]  = eByte;
    expFlags[nTests] = eFlags;
    nTests++;
  endtask

  task automatic buildTable();
    // Name, A, operand, index, F, opcode, CB, pick, read operand, byte, flags
    addTest("ADD_ZERO",   8'h3A, 8'hC6, REG_B, 8'h00, 8'h80, 0, 1, 0, 8'h00, 8'h51);
    addTest("ADD_OVF",    8'h7F, 8'h01, REG_B, 8'h00, 8'h80, 0, 1, 0, 8'h80, 8'h94);
    addTest("ADD_M",      8'h0F, 8'h01, REG_M, 8'h00, 8'h86, 0, 0, 0, 8'h10, 8'h10);
    addTest("ADC_CARRY",  8'h10, 8'h20, REG_B, 8'h01, 8'h88, 0, 1, 0, 8'h31, 8'h20);
    addTest("SUB_HALF",   8'h10, 8'h01, REG_B, 8'h00, 8'h90, 0, 1, 0, 8'h0F, 8'h1A);
    addTest("SUB_OVF",    8'h80, 8'h01, REG_B, 8'h00, 8'h90, 0, 1, 0, 8'h7F, 8'h3E);
    addTest("SUB_ZERO",   8'h42, 8'h42, REG_B, 8'h00, 8'h90, 0, 1, 0, 8'h00, 8'h42);
    addTest("SBC_BORROW", 8'h00, 8'h00, REG_B, 8'h01, 8'h98, 0, 1, 0, 8'hFF, 8'hBB);
    addTest("CP_EQUAL",   8'h28, 8'h28, REG_B, 8'h00, 8'hB8, 0, 1, 0, 8'h28, 8'h6A);
    addTest("CP_LESS",    8'h10, 8'h20, REG_B, 8'h00, 8'hB8, 0, 1, 0, 8'h10, 8'hA3);
    addTest("AND",        8'hF0, 8'h3C, REG_B, 8'h00, 8'hA0, 0, 1, 0, 8'h30, 8'h34);
    addTest("XOR",        8'hFF, 8'hFE, REG_B, 8'hFF, 8'hA8, 0, 1, 0, 8'h01, 8'h00);
    addTest("OR",         8'h81, 8'h06, REG_B, 8'h00, 8'hB0, 0, 1, 0, 8'h87, 8'h84);
    addTest("RLC",        8'h00, 8'h85, REG_B, 8'h00, 8'h00, 1, 1, 1, 8'h0B, 8'h09);
    addTest("RRC",        8'h00, 8'h01, REG_B, 8'h00, 8'h08, 1, 1, 1, 8'h80, 8'h81);
    addTest("RL_CARRY",   8'h00, 8'h40, REG_B, 8'h01, 8'h10, 1, 1, 1, 8'h81, 8'h84);
    addTest("RR",         8'h00, 8'h01, REG_B, 8'h00, 8'h18, 1, 1, 1, 8'h00, 8'h45);
    addTest("SLA",        8'h00, 8'hC0, REG_B, 8'h00, 8'h20, 1, 1, 1, 8'h80, 8'h81);
    addTest("SRA",        8'h00, 8'h8A, REG_B, 8'h00, 8'h28, 1, 1, 1, 8'hC5, 8'h84);
    addTest("SLL",        8'h00, 8'h00, REG_B, 8'hFF, 8'h30, 1, 1, 1, 8'h01, 8'h00);
    addTest("SRL",        8'h00, 8'h81, REG_B, 8'h00, 8'h38, 1, 1, 1, 8'h40, 8'h01);
    addTest("RLCA",       8'h81, 8'h00, REG_B, 8'hC4, 8'h07, 0, 0, 0, 8'h03, 8'hC5);
    addTest("RRA",        8'h01, 8'h00, REG_B, 8'h00, 8'h1F, 0, 0, 0, 8'h00, 8'h01);
    addTest("BIT7_CLEAR", 8'h00, 8'h28, REG_B, 8'h01, 8'h78, 1, 1, 1, 8'h28, 8'h7D);
    addTest("BIT7_SET",   8'h00, 8'h80, REG_B, 8'h00, 8'h78, 1, 1, 1, 8'h80, 8'h90);
    addTest("SET3",       8'h00, 8'h00, REG_B, 8'hA5, 8'hD8, 1, 1, 1, 8'h08, 8'hA5);
    addTest("RES7",       8'h00, 8'hFF, REG_B, 8'h42, 8'hB8, 1, 1, 1, 8'h7F, 8'h42);
    addTest("DAA_ADD",    8'h3C, 8'h00, REG_B, 8'h00, 8'h27, 0, 0, 0, 8'h42, 8'h14);
    addTest("DAA_SUB",    8'h2D, 8'h00, REG_B, 8'h12, 8'h27, 0, 0, 0, 8'h27, 8'h26);
    addTest("DAA_CARRY",  8'h9A, 8'h00, REG_B, 8'h00, 8'h27, 0, 0, 0, 8'h00, 8'h55);
    addTest("INVALID",    8'h33, 8'h00, REG_B, 8'h5A, 8'h76, 0, 0, 0, 8'h33, 8'h5A);
  endtask

  task automatic checkByte(input string name, input dataByte expected, input dataByte actual);
    if (actual !== expected)
    begin
      $display("FAIL %s: register expected %02h, actual %02h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic checkFlags(input string name, input flagByte expected, input flagByte actual);
    if (actual !== expected)
    begin
      $display("FAIL %s: flags expected %02h, actual %02h", name, expected, actual);
      errors++;
    end
  endtask

  // One summary line per test
  task automatic reportTest(input string name, input int errsBefore);
    if (errors == errsBefore)
    begin
      passCount++;
      $display("ok   %s", name);
    end
    else
    begin
      failCount++;
      $display("bad  %s", name);
    end
  endtask

  task automatic checkReset();
    int errsBefore;
    errsBefore = errors;
    for (int i = 0; i < 8; i++)
    begin
      @(posedge clk);
      regSel <= regIdx'(i);
      @(negedge clk);        // Read port settled
      checkByte($sformatf("RESET_R%0d", i), 8'h00, regData);
    end
    checkFlags("RESET_F", 8'h00, flagOut);
    reportTest("RESET", errsBefore);
  endtask

  task automatic runTest(input int t);
    regIdx   idx;
    dataByte op;
    regIdx   rdSel;
    int      errsBefore;
    errsBefore = errors;
    idx = opIdx[t];
    op  = opCode[t];
    if (pickReg[t])
    begin
      idx = regIdx'($unsigned($random(seed)) % 4);   // B to E
      op  = {op[7:3], idx};
    end
    rdSel = readOp[t] ? idx : REG_A;
    @(posedge clk);
    loadEn   <= 1'b1;
    loadSel  <= REG_A;
    loadData <= aVal[t];
    @(posedge clk);
    loadSel  <= idx;
    loadData <= opVal[t];
    @(posedge clk);
    loadEn       <= 1'b0;
    flagLoadEn   <= 1'b1;
    flagLoadData <= fVal[t];
    @(posedge clk);
    flagLoadEn <= 1'b0;
    issue      <= 1'b1;      // Single issue strobe
    cbPrefix   <= cbFlag[t];
    opcode     <= op;
    regSel     <= rdSel;
    @(posedge clk);          // Result written on this edge
    issue <= 1'b0;
    @(negedge clk);
    checkByte(tName[t], expByte[t], regData);
    checkFlags(tName[t], expFlags[t], flagOut);
    reportTest(tName[t], errsBefore);
  endtask

  initial
  begin
    clk          = 1'b0;
    rstN         = 1'b0;
    issue        = 1'b0;
    cbPrefix     = 1'b0;
    opcode       = 8'h00;
    loadEn       = 1'b0;
    loadSel      = REG_B;
    loadData     = 8'h00;
    flagLoadEn   = 1'b0;
    flagLoadData = 8'h00;
    regSel       = REG_B;
    buildTable();
    cycleLimit = nTests * 6 + 50;   // Five edges per test plus reset margin
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    checkReset();
    for (int t = 0; t < nTests; t++)
      runTest(t);
    $display("Tests: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0 && errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
source/cpuAluPkg.sv
source/cpuRegPkg.sv
source/cpuAlu.sv
source/cpuOpDecode.sv
source/cpuRegFile.sv
source/cpuExecTop.sv
verif/cpuExecTb.sv
